// ==== Bender.yml ====
package:
  name: asg

sources:
  - logic/asg_pkg.sv
  - logic/asg_regs.sv
  - logic/asg_table.sv
  - logic/asg_core.sv
  - logic/asg_lin.sv
  - logic/asg_top.sv
  - target: simulation
    files:
      - bench/asg_tb.sv

// ==== bench/asg_tb.sv ====
//////////////////////////////////////////////////
// testbench for the signal generator channel
// loads a ramp table, runs six directed tests and
// checks the DAC stream against a pointer model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_tb;

  import asg_pkg::*;

  logic          bus_reg;  // clock
  logic          rst;
  bus_req_t      bus_req;
  bus_rsp_t      bus_rsp;
  bus_req_t      tbl_req;
  bus_rsp_t      tbl_rsp;
  logic [tn-1:0] trg_ext;
  sample_t       sto_data;
  logic          sto_valid;
  logic          sto_ready;
  logic          evn_sws, evn_per, irq_trg, evn_stp;

  int          errors;
  int          checks;
  int          got_q[$];  // samples taken from the stream
  int          exp_q[$];  // model samples
  int          per_cnt, irq_cnt, stp_cnt, sws_cnt;
  bit          rnd_ready;  // random back-pressure on
  logic [31:0] rd;

  asg_top u_asg_top (
    .bus_reg   (bus_reg),
    .rst       (rst),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .tbl_req   (tbl_req),
    .tbl_rsp   (tbl_rsp),
    .trg_ext   (trg_ext),
    .sto_data  (sto_data),
    .sto_valid (sto_valid),
    .sto_ready (sto_ready),
    .evn_sws   (evn_sws),
    .evn_per   (evn_per),
    .irq_trg   (irq_trg),
    .evn_stp   (evn_stp)
  );

  initial begin
    bus_reg = 1'b0;
    forever #20 bus_reg = ~bus_reg;  // 40 ns period
  end

  //////////////////////////////////////////////////
  // stream monitor, event counters, ready driver
  //////////////////////////////////////////////////

  always @(posedge bus_reg) begin
    if (sto_valid && sto_ready) begin
      got_q.push_back(int'(sto_data));  // signed sample
    end
    if (evn_per) per_cnt++;
    if (irq_trg) irq_cnt++;
    if (evn_stp) stp_cnt++;
    if (evn_sws) sws_cnt++;
  end

  initial begin
    void'($urandom(32'hb90b));  // fixed seed for the back-pressure pattern
    forever begin
      @(posedge bus_reg);
      #2;
      sto_ready = rnd_ready ? 1'($urandom % 2) : 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // ramp contents of the table
  function automatic int ramp(int i);
    return (i * 37) % 8192 - 4096;
  endfunction

  // gain with 13 fraction bits, offset, clamp to 14 bits
  function automatic int lin_ref(int x, int mul, int sum);
    longint p;
    p = longint'(x) * longint'(mul);
    p = (p >>> 13) + sum;
    if (p > 8191) p = 8191;
    if (p < -8192) p = -8192;
    return int'(p);
  endfunction

  // walk the pointer n steps, append shaped samples
  task automatic build_expect(int n, longint off, longint stp, longint siz, int mul, int sum);
    longint ptr;
    int     k;
    ptr = off;
    for (k = 0; k < n; k++) begin
      exp_q.push_back(lin_ref(ramp(int'(ptr >>> 16)), mul, sum));  // integer part
      ptr = ptr + stp;
      if (ptr >= siz) ptr = ptr - siz;  // period wrap
    end
  endtask

  task automatic report_value(string name, int got, int exp);
    errors++;
    $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
  endtask

  //////////////////////////////////////////////////
  // bus access and helpers
  //////////////////////////////////////////////////

  task automatic access(input bit tbl, input bit wr, input logic [13:0] addr,
                        input logic [31:0] wdata, output logic [31:0] rdata);
    bus_req_t req;
    int       n;
    logic     ack;
    req = '{wen: wr, ren: !wr, addr: addr, wdata: wdata};
    if (tbl) tbl_req = req;
    else bus_req = req;
    @(posedge bus_reg);
    #2;
    bus_req = '0;
    tbl_req = '0;
    n = 1;
    ack = tbl ? tbl_rsp.ack : bus_rsp.ack;
    while (!ack && n < 16) begin
      @(posedge bus_reg);
      #2;
      n++;
      ack = tbl ? tbl_rsp.ack : bus_rsp.ack;
    end
    rdata = tbl ? tbl_rsp.rdata : bus_rsp.rdata;
    checks++;
    if (!ack) begin
      errors++;
      $display("timeout: no ack for access to address 'h%0h", addr);
    end else if (n != 1) begin
      errors++;
      $display("ack for address 'h%0h came %0d cycles after the request", addr, n);
    end
  endtask

  task automatic reg_write(input logic [13:0] addr, input logic [31:0] data);
    logic [31:0] dummy;
    access(1'b0, 1'b1, addr, data, dummy);
  endtask

  task automatic reg_read(input logic [13:0] addr, output logic [31:0] data);
    access(1'b0, 1'b0, addr, '0, data);
  endtask

  task automatic clear();
    got_q.delete();
    exp_q.delete();
    per_cnt = 0;
    irq_cnt = 0;
    stp_cnt = 0;
    sws_cnt = 0;
  endtask

  task automatic setup(logic [31:0] off, logic [31:0] stp, logic [31:0] siz,
                       logic [31:0] mul, logic [31:0] sum, logic [31:0] bst);
    reg_write(reg_trg, 32'd0);
    reg_write(reg_off, off);
    reg_write(reg_stp, stp);
    reg_write(reg_siz, siz);
    reg_write(reg_mul, mul);
    reg_write(reg_sum, sum);
    reg_write(reg_bst, bst);
  endtask

  task automatic wait_samples(int n, int limit);
    int c;
    c = 0;
    while (got_q.size() < n && c < limit) begin
      @(posedge bus_reg);
      #2;
      c++;
    end
    if (got_q.size() < n) begin
      errors++;
      $display("timeout: %0d of %0d samples after %0d cycles", got_q.size(), n, limit);
    end
  endtask

  // core reset, then let the linear stage drain
  task automatic stop_gen();
    int c;
    rnd_ready = 1'b0;
    reg_write(reg_ctl, 32'h1);
    c = 0;
    while (sto_valid && c < 20) begin
      @(posedge bus_reg);
      #2;
      c++;
    end
    if (sto_valid) begin
      errors++;
      $display("timeout: stream still valid after core reset");
    end
  endtask

  task automatic compare_samples(int n);
    int i;
    checks++;
    if (got_q.size() < n) begin
      errors++;
      $display("only %0d samples on the stream, %0d expected", got_q.size(), n);
    end
    for (i = 0; i < n && i < got_q.size(); i++) begin
      checks++;
      if (got_q[i] != exp_q[i]) report_value($sformatf("sto_data[%0d]", i), got_q[i], exp_q[i]);
    end
  endtask

  task automatic quiet(int cycles);
    repeat (cycles) @(posedge bus_reg);  // window to prove nothing happens
    #2;
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic readback_regs();
    reg_addr_e   adr [10];
    logic [31:0] msk [10];
    logic [31:0] pat, exp;
    int          i;
    adr = '{reg_trg, reg_siz, reg_off, reg_stp, reg_bst, reg_bdl, reg_bln, reg_bnm,
            reg_mul, reg_sum};
    msk = '{32'hf, 32'h3ff_ffff, 32'h3ff_ffff, 32'h3ff_ffff, 32'h3, 32'h3ff,
            32'hffff_ffff, 32'hffff, 32'h3fff, 32'h3fff};
    for (i = 0; i < 10; i++) begin
      reg_write(adr[i], 32'h9e37_79b9 * (i + 1));
    end
    for (i = 0; i < 10; i++) begin
      pat = 32'h9e37_79b9 * (i + 1);
      exp = pat & msk[i];
      if (i >= 8 && exp[13]) exp = exp | 32'hffff_c000;  // gain and offset are signed
      reg_read(adr[i], rd);
      checks++;
      if (rd != exp) report_value($sformatf("rdata at 'h%0h", adr[i]), int'(rd), int'(exp));
    end
    reg_read(reg_ctl, rd);
    checks++;
    if (rd != 32'h4) report_value("rdata at ctl", int'(rd), 4);  // idle, not running
    access(1'b1, 1'b0, 14'(1000 << 2), '0, rd);
    checks++;
    if (rd != 32'(ramp(1000))) report_value("tbl rdata[1000]", int'(rd), ramp(1000));
  endtask

  task automatic continuous_wrap();
    clear();
    setup(3 << 16, 1 << 16, 16 << 16, 8191, 0, 0);  // 8191 is the largest gain
    build_expect(34, 3 << 16, 1 << 16, 16 << 16, 8191, 0);
    reg_write(reg_ctl, 32'h2);
    checks++;
    if (sws_cnt != 1) report_value("evn_sws count", sws_cnt, 1);
    wait_samples(34, 200);
    checks++;
    if (per_cnt != 2) report_value("evn_per count", per_cnt, 2);  // two wraps so far
    compare_samples(34);
    stop_gen();
  endtask

  task automatic fractional_step();
    clear();
    setup(0, 1 << 15, 16 << 16, 8191, 0, 0);  // half step
    build_expect(40, 0, 1 << 15, 16 << 16, 8191, 0);
    rnd_ready = 1'b1;
    reg_write(reg_ctl, 32'h2);
    wait_samples(40, 2000);
    compare_samples(40);
    stop_gen();
  endtask

  task automatic gain_offset();
    int r;
    int i;
    int mul;
    int sum;
    int nsat;
    for (r = 0; r < 2; r++) begin
      mul = r ? -8192 : 8191;
      sum = r ? -5000 : 5000;
      clear();
      setup(0, 16 << 16, 1008 << 16, mul, sum, 0);
      build_expect(64, 0, 16 << 16, 1008 << 16, mul, sum);
      nsat = 0;
      for (i = 0; i < 64; i++) begin
        if (exp_q[i] == 8191 || exp_q[i] == -8192) nsat++;
      end
      if (nsat == 0) begin
        errors++;
        $display("stimulus of the linear test reaches no saturated value");
      end
      reg_write(reg_ctl, 32'h2);
      wait_samples(64, 300);
      compare_samples(64);
      stop_gen();
    end
  endtask

  task automatic burst_repeat();
    int c;
    clear();
    setup(3 << 16, 1 << 16, 16 << 16, 8191, 0, 32'h1);  // burst on, finite
    reg_write(reg_bdl, 5);
    reg_write(reg_bln, 10);
    reg_write(reg_bnm, 3);
    repeat (3) build_expect(5, 3 << 16, 1 << 16, 16 << 16, 8191, 0);
    reg_write(reg_ctl, 32'h2);
    c = 0;
    while (stp_cnt == 0 && c < 1000) begin
      @(posedge bus_reg);
      #2;
      c++;
    end
    if (stp_cnt == 0) begin
      errors++;
      $display("timeout: burst never reported its stop");
    end
    quiet(10);
    checks++;
    if (got_q.size() != 15) report_value("burst sample count", got_q.size(), 15);
    compare_samples(15);
    checks++;
    if (stp_cnt != 1) report_value("evn_stp count", stp_cnt, 1);
    reg_read(reg_ctl, rd);
    checks++;
    if (rd != 32'h4) report_value("rdata at ctl", int'(rd), 4);
  endtask

  task automatic trigger_mask();
    clear();
    setup(5 << 16, 1 << 16, 16 << 16, 8191, 0, 0);
    reg_write(reg_trg, 32'b0100);  // only bit 2 enabled
    trg_ext = 4'b0001;
    @(posedge bus_reg);
    #2;
    trg_ext = '0;
    quiet(20);
    checks++;
    if (irq_cnt != 0 || got_q.size() != 0) begin
      errors++;
      $display("disabled trigger bit started the generator");
    end
    trg_ext = 4'b0100;
    @(posedge bus_reg);
    #2;
    trg_ext = '0;
    build_expect(8, 5 << 16, 1 << 16, 16 << 16, 8191, 0);
    wait_samples(8, 100);
    checks++;
    if (irq_cnt != 1) report_value("irq_trg count", irq_cnt, 1);
    compare_samples(8);
    stop_gen();
    got_q.delete();
    quiet(20);
    checks++;
    if (got_q.size() != 0) report_value("samples after core reset", got_q.size(), 0);
    reg_read(reg_ctl, rd);
    checks++;
    if (rd != 32'h4) report_value("rdata at ctl", int'(rd), 4);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int i;
    rst       = 1'b1;
    bus_req   = '0;
    tbl_req   = '0;
    trg_ext   = '0;
    sto_ready = 1'b1;
    rnd_ready = 1'b0;
    errors    = 0;
    checks    = 0;
    clear();
    repeat (3) @(posedge bus_reg);
    #2;
    rst = 1'b0;
    for (i = 0; i < 1024; i++) begin
      access(1'b1, 1'b1, 14'(i << 2), 32'(ramp(i)), rd);  // ramp table
    end
    readback_regs();
    continuous_wrap();
    fractional_step();
    gain_offset();
    burst_repeat();
    trigger_mask();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== logic/asg_core.sv ====
//////////////////////////////////////////////////
// generator core, walks the table with a fixed
// point pointer, continuous wrap or burst mode
// sample stream out with valid/ready
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_core #(
  parameter int unsigned cwm = asg_pkg::cwm,
  parameter int unsigned cwf = asg_pkg::cwf,
  parameter int unsigned tn  = asg_pkg::tn
) (
  input  logic              bus_reg,  // clock
  input  logic              rst,
  input  asg_pkg::asg_cfg_t cfg,
  input  logic              ctl_rst,
  input  logic              evn_sws,
  input  logic [tn-1:0]     trg_ext,
  input  asg_pkg::sample_t  rd_data,
  input  logic              ready,
  output logic [cwm-1:0]    rd_addr,
  output asg_pkg::sample_t  data,
  output logic              valid,
  output asg_pkg::asg_sts_t sts,
  output logic              evn_per,
  output logic              irq_trg,
  output logic              evn_stp
);

  import asg_pkg::*;

  localparam int unsigned pw = cwm + cwf;  // pointer width

  core_state_e    state;
  logic [pw-1:0]  siz, off, stp;
  logic [pw-1:0]  ptr, ptr_nxt;
  logic [pw:0]    ptr_sum, ptr_wrp;  // one extra bit against overflow
  logic           wrap;
  logic           rd_vld;  // rd_data holds the sample at ptr
  logic           adv;
  logic           start;
  logic [cwl-1:0] len_cnt;
  logic [cwn-1:0] rep_cnt;
  logic           dat_end, gap_end, rep_end;

  assign siz = cfg.siz[pw-1:0];
  assign off = cfg.off[pw-1:0];
  assign stp = cfg.stp[pw-1:0];

  //////////////////////////////////////////////////
  // start and pointer
  //////////////////////////////////////////////////

  assign start   = evn_sws | (|(trg_ext & cfg.trg[tn-1:0]));  // masked triggers
  assign irq_trg = (state == st_idle) & start & ~ctl_rst;

  // sample moves into the output register
  assign adv = (state == st_data) & rd_vld & (~valid | ready);

  assign ptr_sum = {1'b0, ptr} + {1'b0, stp};
  assign ptr_wrp = ptr_sum - {1'b0, siz};
  assign wrap    = ptr_sum >= {1'b0, siz};  // period end

  // burst phase ends
  assign dat_end = cfg.ben & ((len_cnt + cwl'(1)) >= cwl'(cfg.bdl));
  assign gap_end = (state == st_gap) & ((len_cnt + cwl'(1)) >= cfg.bln);
  assign rep_end = ~cfg.inf & ((rep_cnt + cwn'(1)) >= cfg.bnm);

  // table is addressed with the next pointer, so rd_data tracks ptr
  always_comb begin
    ptr_nxt = ptr;
    if (irq_trg) begin
      ptr_nxt = off;
    end else if (gap_end && !rep_end) begin
      ptr_nxt = off;  // next repetition
    end else if (adv) begin
      ptr_nxt = wrap ? ptr_wrp[pw-1:0] : ptr_sum[pw-1:0];
    end
  end

  assign rd_addr = ptr_nxt[pw-1:cwf];  // integer part only

  //////////////////////////////////////////////////
  // state machine and counters
  //////////////////////////////////////////////////

  always_ff @(posedge bus_reg) begin
    if (rst || ctl_rst) begin
      state   <= st_idle;
      ptr     <= '0;
      rd_vld  <= 1'b0;
      valid   <= 1'b0;
      len_cnt <= '0;
      rep_cnt <= '0;
      evn_per <= 1'b0;
      evn_stp <= 1'b0;
    end else begin
      ptr     <= ptr_nxt;
      evn_per <= adv & wrap;
      evn_stp <= 1'b0;
      if (adv) begin
        valid <= 1'b1;
      end else if (ready) begin
        valid <= 1'b0;  // taken, nothing new behind it
      end
      case (state)
        st_idle: begin
          if (start) begin
            state   <= st_data;
            rd_vld  <= 1'b1;  // table output good next cycle
            len_cnt <= '0;
            rep_cnt <= '0;
          end
        end
        st_data: begin
          if (adv && dat_end) begin
            state   <= st_gap;
            rd_vld  <= 1'b0;
            len_cnt <= '0;
          end else if (adv && cfg.ben) begin
            len_cnt <= len_cnt + cwl'(1);
          end
        end
        st_gap: begin
          if (gap_end) begin
            len_cnt <= '0;
            rep_cnt <= rep_cnt + cwn'(1);
            if (rep_end) begin
              state   <= st_idle;
              evn_stp <= 1'b1;  // last repetition done
            end else begin
              state  <= st_data;
              rd_vld <= 1'b1;
            end
          end else begin
            len_cnt <= len_cnt + cwl'(1);  // idle cycles
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // output register, held under back-pressure
  always_ff @(posedge bus_reg) begin
    if (adv) begin
      data <= rd_data;
    end
  end

  assign sts = '{run: (state != st_idle), bln: len_cnt, bnm: rep_cnt};

endmodule

// ==== logic/asg_lin.sv ====
//////////////////////////////////////////////////
// linear stage on the sample stream
// out = sat((in * mul) >>> 13 + sum), registered
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_lin (
  input  logic             bus_reg,  // clock
  input  logic             rst,
  input  asg_pkg::sample_t mul,
  input  asg_pkg::sample_t sum,
  input  asg_pkg::sample_t sti_data,
  input  logic             sti_valid,
  output logic             sti_ready,
  output asg_pkg::sample_t sto_data,
  output logic             sto_valid,
  input  logic             sto_ready
);

  import asg_pkg::*;

  // saturation limits at accumulator width
  localparam logic signed [2*dw:0] smax = (2*dw+1)'(2**(dw-1) - 1);
  localparam logic signed [2*dw:0] smin = (2*dw+1)'(-(2**(dw-1)));

  logic signed [2*dw-1:0] prd;  // full product
  logic signed [2*dw-1:0] shf;
  logic signed [2*dw:0]   acc;
  sample_t                sat;

  assign prd = sti_data * mul;
  assign shf = prd >>> (dw-1);  // 8192 is unity gain
  assign acc = shf + sum;       // sign extended to acc width

  always_comb begin
    if (acc > smax) begin
      sat = smax[dw-1:0];
    end else if (acc < smin) begin
      sat = smin[dw-1:0];
    end else begin
      sat = acc[dw-1:0];
    end
  end

  // take input when empty or emptied this cycle
  assign sti_ready = ~sto_valid | sto_ready;

  always_ff @(posedge bus_reg) begin
    if (rst) begin
      sto_valid <= 1'b0;
    end else if (sti_ready) begin
      sto_valid <= sti_valid;
    end
  end

  always_ff @(posedge bus_reg) begin
    if (sti_valid && sti_ready) begin
      sto_data <= sat;
    end
  end

endmodule

// ==== logic/asg_pkg.sv ====
//////////////////////////////////////////////////
// shared widths and types for the signal generator
// bus and stream structs, register map, core states
// import inside module bodies, scoped names in ports
//////////////////////////////////////////////////

package asg_pkg;

  // data path and pointer widths
  localparam int unsigned dw  = 14;  // sample width, signed
  localparam int unsigned cwm = 10;  // pointer integer part, table of 2**cwm words
  localparam int unsigned cwf = 16;  // pointer fraction part
  localparam int unsigned cwl = 32;  // burst length counter
  localparam int unsigned cwn = 16;  // burst number counter
  localparam int unsigned tn  = 4;   // external trigger width
  localparam int unsigned baw = 6;   // decoded register address bits

  typedef logic signed [dw-1:0] sample_t;

  // one register bus request, valid when wen or ren is high
  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [13:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // response, ack one cycle after the request
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  // generator configuration
  typedef struct packed {
    logic [tn-1:0]      trg;  // trigger mask
    logic [cwm+cwf-1:0] siz;  // table size, fixed point
    logic [cwm+cwf-1:0] off;  // start offset (phase)
    logic [cwm+cwf-1:0] stp;  // pointer step (frequency)
    logic               ben;  // burst enable
    logic               inf;  // infinite repetitions
    logic [cwm-1:0]     bdl;  // burst data length
    logic [31:0]        bln;  // burst idle length
    logic [15:0]        bnm;  // burst repetitions
    sample_t            mul;  // gain, 8192 is 1.0
    sample_t            sum;  // offset
  } asg_cfg_t;

  // status back to the register block
  typedef struct packed {
    logic           run;
    logic [cwl-1:0] bln;  // length counter
    logic [cwn-1:0] bnm;  // repetition counter
  } asg_sts_t;

  typedef enum logic [baw-1:0] {
    reg_ctl = 'h00,
    reg_trg = 'h04,
    reg_siz = 'h10,
    reg_off = 'h14,
    reg_stp = 'h18,
    reg_bst = 'h20,
    reg_bdl = 'h24,
    reg_bln = 'h28,
    reg_bnm = 'h2c,
    reg_sbl = 'h30,
    reg_sbn = 'h34,
    reg_mul = 'h38,
    reg_sum = 'h3c
  } reg_addr_e;

  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_gap
  } core_state_e;

endpackage

// ==== logic/asg_regs.sv ====
//////////////////////////////////////////////////
// register bus slave of the generator channel
// holds the configuration, makes reset and start
// strobes, returns config and status on reads
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_regs (
  input  logic             bus_reg,  // clock
  input  logic             rst,
  input  asg_pkg::bus_req_t bus_req,
  input  asg_pkg::asg_sts_t sts,
  output asg_pkg::bus_rsp_t bus_rsp,
  output asg_pkg::asg_cfg_t cfg,
  output logic             ctl_rst,
  output logic             evn_sws
);

  import asg_pkg::*;

  reg_addr_e   adr;
  logic        ctl_wen;
  logic        ack;
  logic [31:0] rdata;

  assign adr = reg_addr_e'(bus_req.addr[baw-1:0]);  // low bits only

  //////////////////////////////////////////////////
  // control strobes, nothing stored
  //////////////////////////////////////////////////

  assign ctl_wen = bus_req.wen & (adr == reg_ctl);
  assign ctl_rst = ctl_wen & bus_req.wdata[0];  // core reset
  assign evn_sws = ctl_wen & bus_req.wdata[1];  // software start

  //////////////////////////////////////////////////
  // configuration writes
  //////////////////////////////////////////////////

  always_ff @(posedge bus_reg) begin
    if (rst) begin
      cfg <= '0;
    end else if (bus_req.wen) begin
      case (adr)
        reg_trg: cfg.trg <= bus_req.wdata[tn-1:0];
        reg_siz: cfg.siz <= bus_req.wdata[cwm+cwf-1:0];
        reg_off: cfg.off <= bus_req.wdata[cwm+cwf-1:0];
        reg_stp: cfg.stp <= bus_req.wdata[cwm+cwf-1:0];
        reg_bst: begin
          cfg.ben <= bus_req.wdata[0];
          cfg.inf <= bus_req.wdata[1];
        end
        reg_bdl: cfg.bdl <= bus_req.wdata[cwm-1:0];
        reg_bln: cfg.bln <= bus_req.wdata;
        reg_bnm: cfg.bnm <= bus_req.wdata[15:0];
        reg_mul: cfg.mul <= sample_t'(bus_req.wdata[dw-1:0]);
        reg_sum: cfg.sum <= sample_t'(bus_req.wdata[dw-1:0]);
        default: ;  // ctl and status are not stored here
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read side, registered
  //////////////////////////////////////////////////

  always_ff @(posedge bus_reg) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= bus_req.wen | bus_req.ren;  // every access acked next cycle
    end
  end

  always_ff @(posedge bus_reg) begin
    case (adr)
      reg_ctl: rdata <= {29'd0, ~sts.run, sts.run, 1'b0};
      reg_trg: rdata <= 32'(cfg.trg);
      reg_siz: rdata <= 32'(cfg.siz);
      reg_off: rdata <= 32'(cfg.off);
      reg_stp: rdata <= 32'(cfg.stp);
      reg_bst: rdata <= {30'd0, cfg.inf, cfg.ben};
      reg_bdl: rdata <= 32'(cfg.bdl);
      reg_bln: rdata <= cfg.bln;
      reg_bnm: rdata <= 32'(cfg.bnm);
      reg_sbl: rdata <= 32'(sts.bln);  // live counters
      reg_sbn: rdata <= 32'(sts.bnm);
      reg_mul: rdata <= {{(32-dw){cfg.mul[dw-1]}}, cfg.mul};  // sign extended
      reg_sum: rdata <= {{(32-dw){cfg.sum[dw-1]}}, cfg.sum};
      default: rdata <= '0;
    endcase
  end

  assign bus_rsp = '{ack: ack, rdata: rdata};

endmodule

// ==== logic/asg_table.sv ====
//////////////////////////////////////////////////
// waveform table, one block RAM
// bus port writes and reads words, the generator
// port reads one sample per cycle, both registered
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_table #(
  parameter int unsigned cwm = asg_pkg::cwm
) (
  input  logic              bus_reg,  // clock
  input  asg_pkg::bus_req_t tbl_req,
  input  logic [cwm-1:0]    rd_addr,
  output asg_pkg::bus_rsp_t tbl_rsp,
  output asg_pkg::sample_t  rd_data
);

  import asg_pkg::*;

  sample_t        mem [2**cwm];
  logic [cwm-1:0] tbl_addr;
  logic           ack;
  logic [31:0]    rdata;

  assign tbl_addr = tbl_req.addr[cwm+1:2];  // word address

  // bus port
  always_ff @(posedge bus_reg) begin
    if (tbl_req.wen) begin
      mem[tbl_addr] <= sample_t'(tbl_req.wdata[dw-1:0]);
    end
    rdata <= {{(32-dw){mem[tbl_addr][dw-1]}}, mem[tbl_addr]};  // sign extend
    ack   <= tbl_req.wen | tbl_req.ren;
  end

  // generator port, one cycle latency
  always_ff @(posedge bus_reg) begin
    rd_data <= mem[rd_addr];
  end

  assign tbl_rsp = '{ack: ack, rdata: rdata};

endmodule

// ==== logic/asg_top.sv ====
//////////////////////////////////////////////////
// generator channel top, registers, waveform table
// core and linear stage, stream goes to the DAC
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asg_top #(
  parameter int unsigned cwm = asg_pkg::cwm,
  parameter int unsigned cwf = asg_pkg::cwf,
  parameter int unsigned tn  = asg_pkg::tn
) (
  input  logic              bus_reg,  // clock
  input  logic              rst,
  input  asg_pkg::bus_req_t bus_req,  // register bus
  output asg_pkg::bus_rsp_t bus_rsp,
  input  asg_pkg::bus_req_t tbl_req,  // table bus
  output asg_pkg::bus_rsp_t tbl_rsp,
  input  logic [tn-1:0]     trg_ext,
  output asg_pkg::sample_t  sto_data,
  output logic              sto_valid,
  input  logic              sto_ready,
  output logic              evn_sws,
  output logic              evn_per,
  output logic              irq_trg,
  output logic              evn_stp
);

  import asg_pkg::*;

  asg_cfg_t       cfg;
  asg_sts_t       sts;
  logic           ctl_rst;
  logic [cwm-1:0] rd_addr;
  sample_t        rd_data;
  sample_t        stg_data;  // core to linear stage
  logic           stg_valid;
  logic           stg_ready;

  asg_regs u_regs (
    .bus_reg (bus_reg),
    .rst     (rst),
    .bus_req (bus_req),
    .sts     (sts),
    .bus_rsp (bus_rsp),
    .cfg     (cfg),
    .ctl_rst (ctl_rst),
    .evn_sws (evn_sws)
  );

  asg_table #(.cwm(cwm)) u_table (
    .bus_reg (bus_reg),
    .tbl_req (tbl_req),
    .rd_addr (rd_addr),
    .tbl_rsp (tbl_rsp),
    .rd_data (rd_data)
  );

  asg_core #(.cwm(cwm), .cwf(cwf), .tn(tn)) u_core (
    .bus_reg (bus_reg),
    .rst     (rst),
    .cfg     (cfg),
    .ctl_rst (ctl_rst),
    .evn_sws (evn_sws),
    .trg_ext (trg_ext),
    .rd_data (rd_data),
    .ready   (stg_ready),
    .rd_addr (rd_addr),
    .data    (stg_data),
    .valid   (stg_valid),
    .sts     (sts),
    .evn_per (evn_per),
    .irq_trg (irq_trg),
    .evn_stp (evn_stp)
  );

  asg_lin u_lin (
    .bus_reg   (bus_reg),
    .rst       (rst),
    .mul       (cfg.mul),
    .sum       (cfg.sum),
    .sti_data  (stg_data),
    .sti_valid (stg_valid),
    .sti_ready (stg_ready),
    .sto_data  (sto_data),
    .sto_valid (sto_valid),
    .sto_ready (sto_ready)
  );

endmodule

// ==== src.f ====
logic/asg_pkg.sv
logic/asg_regs.sv
logic/asg_table.sv
logic/asg_core.sv
logic/asg_lin.sv
logic/asg_top.sv
bench/asg_tb.sv
